/* common/read_datapath_pkg.sv */
// Shared widths, latencies, vector types and the read request struct for the AFI read datapath
package read_datapath_pkg;

	// ******************************
	// Interface geometry
	// ******************************

	// Half rate, so every AFI clock carries two phases
	localparam int AFI_RATE_RATIO = 2;

	// Memory side DQ width and the split into read DQS groups
	localparam int MEM_DQ_WIDTH = 16;
	localparam int READ_DQS_GROUPS = 2;
	localparam int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / READ_DQS_GROUPS;

	// DDR gives two beats per memory clock, two memory clocks per AFI clock
	localparam int NUM_TIMESLOTS = 2 * AFI_RATE_RATIO;

	// One AFI clock worth of read data across all groups and slots
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIMESLOTS;

	// One OCT control per DQS group per AFI phase
	localparam int AFI_DQS_WIDTH = READ_DQS_GROUPS * AFI_RATE_RATIO;

	// ******************************
	// Latency settings
	// ******************************

	// Depth of the read latency shift register, also the largest legal latency
	localparam int MAX_READ_LATENCY = 16;

	// Extra flops ahead of the latency shift register
	localparam int EXTRA_VFIFO_SHIFT = 1;

	// Memory read latency in memory clocks
	localparam int MEM_T_RL = 11;

	// OCT window edges in AFI cycles, derived from the memory read latency
	// The on edge opens early enough to cover the preamble
	localparam int OCT_ON_DELAY = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// ******************************
	// Vector types
	// ******************************

	// Read data for one AFI clock
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;

	// A single DQS group in a single time slot
	typedef logic [DQ_GROUP_WIDTH-1:0] dq_group_t;

	// One bit per AFI phase
	typedef logic [AFI_RATE_RATIO-1:0] afi_phase_vec_t;

	// Read latency in AFI cycles, wide enough to hold MAX_READ_LATENCY itself
	typedef logic [$clog2(MAX_READ_LATENCY):0] lat_count_t;

	// Every tap of the latency shift register
	typedef logic [MAX_READ_LATENCY-1:0] latency_taps_t;

	// OCT force off, one bit per strobe
	typedef logic [AFI_DQS_WIDTH-1:0] oct_vec_t;

	// Read request from the controller for one AFI clock
	// rdata_en marks the cycles that return data to the AFI
	// rdata_en_full spans the whole burst and drives the OCT window
	typedef struct packed {
		afi_phase_vec_t rdata_en;
		afi_phase_vec_t rdata_en_full;
	} afi_read_req_t;

endpackage

/* hw/read_valid/read_latency_shifter.sv */
// Read enable delay line, feeds every read latency tap to the read valid selector
`timescale 1ns/10ps

module read_latency_shifter (
	input  logic                             pll_afi_clk,
	input  logic                             reset_n_afi_clk,
	input  logic                             rdata_en_i,
	output read_datapath_pkg::latency_taps_t latency_taps_o
);

	// Extra delay flops ahead of the latency register
	logic [read_datapath_pkg::EXTRA_VFIFO_SHIFT-1:0] extra_shift;

	// Extra delay chain with the live enable appended at the bottom
	logic [read_datapath_pkg::EXTRA_VFIFO_SHIFT:0] extra_shift_in;

	// Read enable after the extra delay
	logic rdata_en_delayed;

	assign extra_shift_in = {extra_shift, rdata_en_i};

	// Oldest stage of the extra delay feeds the latency register
	assign rdata_en_delayed = extra_shift_in[read_datapath_pkg::EXTRA_VFIFO_SHIFT];

	// Extra delay stages
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			extra_shift <= '0;
		end
		else
		begin
			extra_shift <= extra_shift_in[read_datapath_pkg::EXTRA_VFIFO_SHIFT-1:0];
		end
	end

	// Latency register, tap j holds the enable from j+1 cycles after the extra delay
	// All taps stay visible so the sequencer can sweep the latency at run time
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_taps_o <= '0;
		end
		else
		begin
			latency_taps_o <= {latency_taps_o[read_datapath_pkg::MAX_READ_LATENCY-2:0],
				rdata_en_delayed};
		end
	end

	// No stale read token may survive a reset into the first cycle
	a_taps_clear_after_reset : assert property (
		@(posedge pll_afi_clk)
		$rose(reset_n_afi_clk) |-> (latency_taps_o == '0)
	);

endmodule

/* hw/read_valid/read_valid_selector.sv */
// Read valid selector, picks the calibrated latency tap and registers it as AFI read valid
`timescale 1ns/10ps

module read_valid_selector (
	input  logic                              pll_afi_clk,
	input  logic                              reset_n_afi_clk,
	input  read_datapath_pkg::latency_taps_t  latency_taps_i,
	input  read_datapath_pkg::lat_count_t     seq_read_latency_i,
	output read_datapath_pkg::afi_phase_vec_t afi_rdata_valid_o
);

	// Sequencer latency minus one, since the sequencer counts from one
	read_datapath_pkg::lat_count_t tap_index;

	// The tap at the calibrated latency
	logic selected_tap;

	assign tap_index = seq_read_latency_i - read_datapath_pkg::lat_count_t'(1);

	// Only the low bits address the taps, the top bit is set only for out of range values
	assign selected_tap =
		latency_taps_i[tap_index[$clog2(read_datapath_pkg::MAX_READ_LATENCY)-1:0]];

	// ******************************
	// Per phase valid registers
	// ******************************

	// Every phase gets its own flop so each can sit close to its consumer
	// All of them take phase 0 of the enable, as half rate reads span both phases
	genvar phase;

	for (phase = 0; phase < read_datapath_pkg::AFI_RATE_RATIO; phase++)
	begin : phase_valid
		logic valid_r;

		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
		begin
			if (!reset_n_afi_clk)
			begin
				valid_r <= 1'b0;
			end
			else
			begin
				valid_r <= selected_tap;
			end
		end

		assign afi_rdata_valid_o[phase] = valid_r;
	end

	// ******************************
	// Checks
	// ******************************

	// The sequencer must keep the latency inside the shift register
	// A zero latency would wrap to the last tap and look like a long latency
	a_latency_in_range : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(seq_read_latency_i >= read_datapath_pkg::lat_count_t'(1)) &&
		(seq_read_latency_i <= read_datapath_pkg::lat_count_t'(read_datapath_pkg::MAX_READ_LATENCY))
	);

endmodule

/* hw/oct/oct_control.sv */
// On die termination control, forces OCT off outside a window around each read burst
`timescale 1ns/10ps

module oct_control (
	input  logic                             pll_afi_clk,
	input  logic                             reset_n_afi_clk,
	input  read_datapath_pkg::afi_read_req_t afi_read_req_i,
	output read_datapath_pkg::oct_vec_t      force_oct_off_o
);

	// Full read enable, phase 0 covers the whole half rate burst
	logic rdata_en_full;

	// Past values of the full read enable, bit i is i+1 cycles old
	logic [read_datapath_pkg::OCT_OFF_DELAY-1:0] rdata_en_hist;

	// History with the live enable at bit 0, bit i is i cycles old
	logic [read_datapath_pkg::OCT_OFF_DELAY:0] rdata_en_window;

	// True while any enable in the termination window is set
	logic oct_needed;

	assign rdata_en_full = afi_read_req_i.rdata_en_full[0];
	assign rdata_en_window = {rdata_en_hist, rdata_en_full};

	// Data arrives OCT_ON_DELAY cycles after the request at the earliest
	// and is gone OCT_OFF_DELAY cycles after it
	assign oct_needed = |rdata_en_window[read_datapath_pkg::OCT_OFF_DELAY:
		read_datapath_pkg::OCT_ON_DELAY];

	// Enable history
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_hist <= '0;
		end
		else
		begin
			rdata_en_hist <= rdata_en_window[read_datapath_pkg::OCT_OFF_DELAY-1:0];
		end
	end

	// ******************************
	// Per strobe force off
	// ******************************

	// One flop per strobe keeps the fanout local to each DQS pin
	genvar strobe;

	for (strobe = 0; strobe < read_datapath_pkg::AFI_DQS_WIDTH; strobe++)
	begin : strobe_oct
		logic oct_off_r;

		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
		begin
			if (!reset_n_afi_clk)
			begin
				oct_off_r <= 1'b0;
			end
			else
			begin
				oct_off_r <= ~oct_needed;
			end
		end

		assign force_oct_off_o[strobe] = oct_off_r;
	end

	// ******************************
	// Checks
	// ******************************

	// All strobes see the same window, termination must switch together
	a_strobes_agree : assert property (
		@(posedge pll_afi_clk)
		force_oct_off_o == {read_datapath_pkg::AFI_DQS_WIDTH{force_oct_off_o[0]}}
	);

	// Once the enable has been quiet longer than the window, OCT must be released
	a_oct_released : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(!rdata_en_full) [* (read_datapath_pkg::OCT_OFF_DELAY + 1)] |=> (&force_oct_off_o)
	);

endmodule

/* hw/read_datapath.sv */
// AFI clock read datapath top, connects read valid and OCT control and reorders the read data buses
`timescale 1ns/10ps

module read_datapath (
	input  logic                              pll_afi_clk,
	input  logic                              reset_n_afi_clk,
	input  read_datapath_pkg::afi_read_req_t  afi_read_req_i,
	input  read_datapath_pkg::lat_count_t     seq_read_latency_i,
	input  read_datapath_pkg::afi_data_t      ddio_phy_dq_i,
	output read_datapath_pkg::afi_data_t      afi_rdata_o,
	output read_datapath_pkg::afi_data_t      phy_mux_read_fifo_q_o,
	output read_datapath_pkg::afi_phase_vec_t afi_rdata_valid_o,
	output read_datapath_pkg::oct_vec_t       force_oct_off_o
);

	// Every tap of the read latency shift register
	read_datapath_pkg::latency_taps_t latency_taps;

	// Phase 0 of the read enable stands for both phases
	logic rdata_en_ph0;

	assign rdata_en_ph0 = afi_read_req_i.rdata_en[0];

	// ******************************
	// Read valid generation
	// ******************************

	// Delays the read enable and exposes all latency taps
	read_latency_shifter read_latency_shifter_i (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_i      (rdata_en_ph0),
		.latency_taps_o  (latency_taps)
	);

	// Picks the tap chosen by the sequencer during calibration
	read_valid_selector read_valid_selector_i (
		.pll_afi_clk        (pll_afi_clk),
		.reset_n_afi_clk    (reset_n_afi_clk),
		.latency_taps_i     (latency_taps),
		.seq_read_latency_i (seq_read_latency_i),
		.afi_rdata_valid_o  (afi_rdata_valid_o)
	);

	// ******************************
	// On die termination
	// ******************************

	// Keeps termination on around every read burst
	oct_control oct_control_i (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_read_req_i  (afi_read_req_i),
		.force_oct_off_o (force_oct_off_o)
	);

	// ******************************
	// Read data reordering
	// ******************************

	// The DDIO bus is grouped by DQS group first and by time slot within a group
	// G1_T3 G1_T2 G1_T1 G1_T0 G0_T3 G0_T2 G0_T1 G0_T0
	// The AFI bus is grouped by time slot first and by DQS group within a slot
	// G1_T3 G0_T3 G1_T2 G0_T2 G1_T1 G0_T1 G1_T0 G0_T0
	genvar grp;
	genvar slot;

	for (grp = 0; grp < read_datapath_pkg::READ_DQS_GROUPS; grp++)
	begin : afi_group_map
		for (slot = 0; slot < read_datapath_pkg::NUM_TIMESLOTS; slot++)
		begin : afi_slot_map
			read_datapath_pkg::dq_group_t beat;

			// Pick group grp, slot slot out of the capture bus
			assign beat = ddio_phy_dq_i[(grp * read_datapath_pkg::NUM_TIMESLOTS + slot)
				* read_datapath_pkg::DQ_GROUP_WIDTH +: read_datapath_pkg::DQ_GROUP_WIDTH];

			// Place it in slot major order for the controller
			assign afi_rdata_o[(slot * read_datapath_pkg::READ_DQS_GROUPS + grp)
				* read_datapath_pkg::DQ_GROUP_WIDTH +: read_datapath_pkg::DQ_GROUP_WIDTH] = beat;
		end
	end

	// The sequencer calibrates each group on its own, so it wants group major order
	// This undoes the slot major mapping of the AFI bus
	for (grp = 0; grp < read_datapath_pkg::READ_DQS_GROUPS; grp++)
	begin : seq_group_map
		for (slot = 0; slot < read_datapath_pkg::NUM_TIMESLOTS; slot++)
		begin : seq_slot_map
			read_datapath_pkg::dq_group_t beat;

			assign beat = afi_rdata_o[(slot * read_datapath_pkg::READ_DQS_GROUPS + grp)
				* read_datapath_pkg::DQ_GROUP_WIDTH +: read_datapath_pkg::DQ_GROUP_WIDTH];

			assign phy_mux_read_fifo_q_o[(grp * read_datapath_pkg::NUM_TIMESLOTS + slot)
				* read_datapath_pkg::DQ_GROUP_WIDTH +: read_datapath_pkg::DQ_GROUP_WIDTH] = beat;
		end
	end

endmodule

/* sim/tb_clock_gen.sv */
// Testbench clock and reset source, a 4 ns clock with reset held over the first four rising edges
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int HALF_PERIOD_NS = 2;
	localparam int RESET_CYCLES = 4;

	initial
	begin
		clk_o = 1'b0;
		forever
		begin
			#HALF_PERIOD_NS clk_o = ~clk_o;
		end
	end

	// Reset starts high so that its falling edge reaches the asynchronous reset flops
	initial
	begin
		rst_n_o = 1'b1;
		#1 rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		// Release on a falling edge, half a period away from any sampling edge
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

/* sim/read_datapath_tb.sv */
// Testbench for the AFI read datapath, drives requests and capture data and checks all outputs
`timescale 1ns/10ps

module read_datapath_tb;

	// ******************************
	// Run sizes and limits
	// ******************************

	localparam int DATA_VECTORS = 20;
	localparam int LATENCY_TRIALS = 3;
	localparam int BURST_REQUESTS = 6;

	// Requests start at most four cycles apart, so this latency keeps several in flight
	localparam int MIN_BURST_LATENCY = 6;

	// Number of legal latencies from MIN_BURST_LATENCY up to the deepest tap
	localparam int BURST_LATENCY_SPAN = read_datapath_pkg::MAX_READ_LATENCY - MIN_BURST_LATENCY + 1;

	// Idle time that empties every latency tap, the valid flop and the OCT window
	localparam int DRAIN_CYCLES = read_datapath_pkg::MAX_READ_LATENCY + 4;

	// Upper bound of each test in cycles, reset, data, latency, burst and OCT
	localparam int TEST_BUDGET = 10 + 30 + 90 + 110 + 60;
	localparam int TIMEOUT_CYCLES = 2 * TEST_BUDGET;

	localparam logic [31:0] RNG_SEED = 32'd58;

	logic                              pll_afi_clk;
	logic                              reset_n_afi_clk;
	read_datapath_pkg::afi_read_req_t  afi_read_req;
	read_datapath_pkg::lat_count_t     seq_read_latency;
	read_datapath_pkg::afi_data_t      ddio_phy_dq;
	read_datapath_pkg::afi_data_t      afi_rdata;
	read_datapath_pkg::afi_data_t      phy_mux_read_fifo_q;
	read_datapath_pkg::afi_phase_vec_t afi_rdata_valid;
	read_datapath_pkg::oct_vec_t       force_oct_off;

	// Request history, bit i holds the value sampled i rising edges ago
	logic [read_datapath_pkg::MAX_READ_LATENCY+1:0] en_hist;
	logic [read_datapath_pkg::OCT_OFF_DELAY:0]      full_hist;

	// Set from the first edge after reset, before it the OCT output is still in reset
	logic oct_armed;

	read_datapath_pkg::lat_count_t     hist_index;
	read_datapath_pkg::afi_phase_vec_t expected_valid;
	read_datapath_pkg::oct_vec_t       expected_oct;

	int          error_count = 0;
	int          clean_tests = 0;
	int          dirty_tests = 0;
	int          cycle_count = 0;
	int          valid_high_count;
	int          oct_low_count;
	logic [31:0] rng_state = RNG_SEED;

	tb_clock_gen tb_clock_gen_i (
		.clk_o   (pll_afi_clk),
		.rst_n_o (reset_n_afi_clk)
	);

	read_datapath read_datapath_i (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.afi_read_req_i        (afi_read_req),
		.seq_read_latency_i    (seq_read_latency),
		.ddio_phy_dq_i         (ddio_phy_dq),
		.afi_rdata_o           (afi_rdata),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q),
		.afi_rdata_valid_o     (afi_rdata_valid),
		.force_oct_off_o       (force_oct_off)
	);

	// ******************************
	// Helpers
	// ******************************

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] random_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Slot g*32 + t*8 of the capture bus lands at t*16 + g*8 on the AFI bus
	function automatic read_datapath_pkg::afi_data_t reorder_by_slot(
		input read_datapath_pkg::afi_data_t capture
	);
		read_datapath_pkg::afi_data_t ordered;
		int src_lsb;
		int dst_lsb;
		ordered = '0;
		for (int grp = 0; grp < read_datapath_pkg::READ_DQS_GROUPS; grp++)
		begin
			for (int slot = 0; slot < read_datapath_pkg::NUM_TIMESLOTS; slot++)
			begin
				src_lsb = (grp * read_datapath_pkg::NUM_TIMESLOTS + slot) * 8;
				dst_lsb = slot * read_datapath_pkg::MEM_DQ_WIDTH + grp * 8;
				ordered[dst_lsb +: 8] = capture[src_lsb +: 8];
			end
		end
		return ordered;
	endfunction

	task automatic report_mismatch(
		input string       signal_name,
		input logic [63:0] expected,
		input logic [63:0] actual
	);
		$display("error at %0d ns: %s expected %h actual %h", $time, signal_name, expected, actual);
		error_count++;
	endtask

	task automatic finish_test(input string test_name, input int errors_before);
		int errors;
		errors = error_count - errors_before;
		$display("%s: done with %0d errors", test_name, errors);
		if (errors == 0)
		begin
			clean_tests++;
		end
		else
		begin
			dirty_tests++;
		end
	endtask

	// One clock of request, both phases carry the same value
	task automatic step_cycle(input logic en, input logic full);
		@(posedge pll_afi_clk);
		afi_read_req.rdata_en <= {read_datapath_pkg::AFI_RATE_RATIO{en}};
		afi_read_req.rdata_en_full <= {read_datapath_pkg::AFI_RATE_RATIO{full}};
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) step_cycle(1'b0, 1'b0);
	endtask

	// The sequencer only moves the latency while no read is in flight
	task automatic set_latency(input read_datapath_pkg::lat_count_t latency);
		@(posedge pll_afi_clk);
		seq_read_latency <= latency;
		afi_read_req <= '0;
		idle_cycles(1);
	endtask

	task automatic single_read_trial(input read_datapath_pkg::lat_count_t latency);
		int valid_start;
		set_latency(latency);
		valid_start = valid_high_count;
		step_cycle(1'b1, 1'b1);
		idle_cycles(DRAIN_CYCLES);
		a_single_valid_count : assert (valid_high_count - valid_start == 1)
		else report_mismatch("afi_rdata_valid_o high cycles", 64'(1),
			64'(valid_high_count - valid_start));
	endtask

	// Mixed one and two cycle requests with one or two idle cycles between them
	task automatic burst_trial(input read_datapath_pkg::lat_count_t latency);
		int valid_start;
		int enable_cycles;
		int req_len;
		int gap_len;
		set_latency(latency);
		valid_start = valid_high_count;
		enable_cycles = 0;
		for (int req = 0; req < BURST_REQUESTS; req++)
		begin
			req_len = 1 + int'(random_word() % 2);
			gap_len = 1 + int'(random_word() % 2);
			repeat (req_len) step_cycle(1'b1, 1'b1);
			idle_cycles(gap_len);
			enable_cycles += req_len;
		end
		idle_cycles(DRAIN_CYCLES);
		a_burst_valid_count : assert (valid_high_count - valid_start == enable_cycles)
		else report_mismatch("afi_rdata_valid_o high cycles", 64'(enable_cycles),
			64'(valid_high_count - valid_start));
	endtask

	// A second pulse second_offset cycles later stretches the window by that much
	task automatic oct_pulse_trial(input int second_offset);
		int low_start;
		int expected_low;
		expected_low = read_datapath_pkg::OCT_OFF_DELAY - read_datapath_pkg::OCT_ON_DELAY + 1
			+ second_offset;
		low_start = oct_low_count;
		step_cycle(1'b0, 1'b1);
		if (second_offset > 0)
		begin
			idle_cycles(second_offset - 1);
			step_cycle(1'b0, 1'b1);
		end
		idle_cycles(DRAIN_CYCLES);
		a_oct_window_length : assert (oct_low_count - low_start == expected_low)
		else report_mismatch("force_oct_off_o low cycles", 64'(expected_low),
			64'(oct_low_count - low_start));
	endtask

	// ******************************
	// Reference model and monitors
	// ******************************

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist <= '0;
			full_hist <= '0;
			oct_armed <= 1'b0;
			valid_high_count <= 0;
			oct_low_count <= 0;
		end
		else
		begin
			en_hist <= {en_hist[read_datapath_pkg::MAX_READ_LATENCY:0], afi_read_req.rdata_en[0]};
			full_hist <= {full_hist[read_datapath_pkg::OCT_OFF_DELAY-1:0],
				afi_read_req.rdata_en_full[0]};
			oct_armed <= 1'b1;
			if (afi_rdata_valid == 2'b11)
			begin
				valid_high_count <= valid_high_count + 1;
			end
			if (force_oct_off == '0)
			begin
				oct_low_count <= oct_low_count + 1;
			end
		end
	end

	// A read sampled at edge k shows valid after edge k+L+1
	// OCT is forced on while any full enable from edges m-8 to m-3 was set
	always_comb
	begin
		hist_index = seq_read_latency + read_datapath_pkg::lat_count_t'(1);
		expected_valid = {read_datapath_pkg::AFI_RATE_RATIO{en_hist[hist_index]}};
		if (oct_armed)
		begin
			expected_oct = {read_datapath_pkg::AFI_DQS_WIDTH{~(|full_hist[
				read_datapath_pkg::OCT_OFF_DELAY:read_datapath_pkg::OCT_ON_DELAY])}};
		end
		else
		begin
			expected_oct = '0;
		end
	end

	// ******************************
	// Checking assertions
	// ******************************

	a_reset_valid_low : assert property (
		@(posedge pll_afi_clk)
		(!reset_n_afi_clk || $rose(reset_n_afi_clk)) |-> (afi_rdata_valid == '0)
	) else report_mismatch("afi_rdata_valid_o", 64'(0), 64'($sampled(afi_rdata_valid)));

	a_reset_oct_low : assert property (
		@(posedge pll_afi_clk)
		(!reset_n_afi_clk || $rose(reset_n_afi_clk)) |-> (force_oct_off == '0)
	) else report_mismatch("force_oct_off_o", 64'(0), 64'($sampled(force_oct_off)));

	a_afi_rdata_order : assert property (
		@(posedge pll_afi_clk)
		afi_rdata == reorder_by_slot(ddio_phy_dq)
	) else report_mismatch("afi_rdata_o", reorder_by_slot($sampled(ddio_phy_dq)),
		$sampled(afi_rdata));

	a_phy_mux_order : assert property (
		@(posedge pll_afi_clk)
		phy_mux_read_fifo_q == ddio_phy_dq
	) else report_mismatch("phy_mux_read_fifo_q_o", $sampled(ddio_phy_dq),
		$sampled(phy_mux_read_fifo_q));

	a_rdata_valid : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid == expected_valid
	) else report_mismatch("afi_rdata_valid_o", 64'($sampled(expected_valid)),
		64'($sampled(afi_rdata_valid)));

	a_force_oct_off : assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		force_oct_off == expected_oct
	) else report_mismatch("force_oct_off_o", 64'($sampled(expected_oct)),
		64'($sampled(force_oct_off)));

	// ******************************
	// Stimulus and run control
	// ******************************

	always @(posedge pll_afi_clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	initial
	begin
		int errors_before;
		read_datapath_pkg::lat_count_t burst_latency;
		afi_read_req = '0;
		seq_read_latency = read_datapath_pkg::lat_count_t'(4);
		ddio_phy_dq = '0;

		// Outputs stay low through reset and the first cycle after it
		errors_before = error_count;
		wait (reset_n_afi_clk === 1'b0);
		@(posedge reset_n_afi_clk);
		idle_cycles(2);
		finish_test("reset", errors_before);

		errors_before = error_count;
		for (int vec = 0; vec < DATA_VECTORS; vec++)
		begin
			@(posedge pll_afi_clk);
			ddio_phy_dq <= {random_word(), random_word()};
		end
		idle_cycles(2);
		finish_test("data reordering", errors_before);

		errors_before = error_count;
		for (int trial = 0; trial < LATENCY_TRIALS; trial++)
		begin
			single_read_trial(read_datapath_pkg::lat_count_t'(
				random_word() % read_datapath_pkg::MAX_READ_LATENCY + 1));
		end
		finish_test("read valid latency", errors_before);

		// Second round runs at a new latency once the pipeline is empty
		errors_before = error_count;
		burst_latency = read_datapath_pkg::lat_count_t'(random_word() % BURST_LATENCY_SPAN
			+ MIN_BURST_LATENCY);
		burst_trial(burst_latency);
		// A step of 1 to SPAN-1 within the span always lands on another latency
		burst_latency = read_datapath_pkg::lat_count_t'((burst_latency - MIN_BURST_LATENCY + 1
			+ random_word() % (BURST_LATENCY_SPAN - 1)) % BURST_LATENCY_SPAN
			+ MIN_BURST_LATENCY);
		burst_trial(burst_latency);
		finish_test("reads in flight", errors_before);

		errors_before = error_count;
		oct_pulse_trial(0);
		oct_pulse_trial(3);
		finish_test("oct window", errors_before);

		$display("summary: %0d tests clean, %0d tests with errors, %0d errors in total",
			clean_tests, dirty_tests, error_count);
		if (error_count == 0 && dirty_tests == 0)
		begin
			$display("test passed");
		end
		else
		begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* src.f */
common/read_datapath_pkg.sv
hw/read_valid/read_latency_shifter.sv
hw/read_valid/read_valid_selector.sv
hw/oct/oct_control.sv
hw/read_datapath.sv
sim/tb_clock_gen.sv
sim/read_datapath_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module read_datapath_tb -f src.f \
	&& ./obj_dir/Vread_datapath_tb | tee /dev/stderr | grep -x "test passed" > /dev/null \
	&& echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }
